// ==== design/rp_defs.svh ====
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

////////////////////////////////////////////////////////////
// channel counts
////////////////////////////////////////////////////////////

// analog channels per direction
`define RP_CHN 2
// pdm outputs
`define RP_PDM_CHN 4

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// adc and dac sample width
`define RP_SMP_W 14
// gain word, fixed point
`define RP_GAIN_W 16
// binary point of the gain
`define RP_GAIN_SHIFT 14
// 1.0 in gain units, reset value
`define RP_GAIN_UNITY 16384

// pdm level and period
`define RP_PDM_W 8
`define RP_PDM_RANGE 255

////////////////////////////////////////////////////////////
// register bus
////////////////////////////////////////////////////////////

`define RP_ADDR_W 8
`define RP_DATA_W 32

`endif

// ==== design/rp_pkg.sv ====
`include "rp_defs.svh"

package rp_pkg;

  // signed sample after offset-binary conversion
  typedef logic signed [`RP_SMP_W-1:0] sample_t;

  // calibration gain and offset
  typedef logic signed [`RP_GAIN_W-1:0] gain_t;
  typedef logic signed [`RP_SMP_W-1:0] offset_t;

  // pdm duty level, unsigned
  typedef logic [`RP_PDM_W-1:0] pdm_lvl_t;

  // register map, byte addresses
  typedef enum logic [`RP_ADDR_W-1:0] {
    REG_CTRL      = 8'h00,  // bit 0 digital loopback
    REG_ADC_GAIN0 = 8'h04,
    REG_ADC_GAIN1 = 8'h08,
    REG_ADC_OFFS0 = 8'h0C,
    REG_ADC_OFFS1 = 8'h10,
    REG_DAC_GAIN0 = 8'h14,
    REG_DAC_GAIN1 = 8'h18,
    REG_DAC_OFFS0 = 8'h1C,
    REG_DAC_OFFS1 = 8'h20,
    REG_PDM0      = 8'h24,
    REG_PDM1      = 8'h28,
    REG_PDM2      = 8'h2C,
    REG_PDM3      = 8'h30
  } reg_addr_e;

endpackage

// ==== design/calib_cfg_if.sv ====
`timescale 1ns/100ps

`include "rp_defs.svh"

interface calib_cfg_if;

  // adc input replaced by dac samples
  logic digital_loop;

  // adc calibration, per channel
  rp_pkg::gain_t   [`RP_CHN-1:0] adc_gain;
  rp_pkg::offset_t [`RP_CHN-1:0] adc_offs;

  // dac calibration, per channel
  rp_pkg::gain_t   [`RP_CHN-1:0] dac_gain;
  rp_pkg::offset_t [`RP_CHN-1:0] dac_offs;

  // register block drives everything
  modport regs_mp (output digital_loop, adc_gain, adc_offs, dac_gain, dac_offs);

  // adc side also needs the loopback select
  modport adc_mp (input digital_loop, adc_gain, adc_offs);

  modport dac_mp (input dac_gain, dac_offs);

endinterface

// ==== design/rp_regs.sv ====
`timescale 1ns/100ps

`include "rp_defs.svh"

module rp_regs (
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // register bus
  input  logic [`RP_ADDR_W-1:0]               sys_addr_i,
  input  logic [`RP_DATA_W-1:0]               sys_wdata_i,
  input  logic                                sys_wen_i,
  input  logic                                sys_ren_i,
  output logic [`RP_DATA_W-1:0]               sys_rdata_o,
  output logic                                sys_ack_o,
  output logic                                sys_err_o,
  // pdm levels
  output rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0]  pdm_lvl_o,
  // calibration and loopback
  calib_cfg_if.regs_mp                        cfg
);

  logic                                loop_q;
  rp_pkg::gain_t    [`RP_CHN-1:0]      adc_gain_q;
  rp_pkg::offset_t  [`RP_CHN-1:0]      adc_offs_q;
  rp_pkg::gain_t    [`RP_CHN-1:0]      dac_gain_q;
  rp_pkg::offset_t  [`RP_CHN-1:0]      dac_offs_q;
  rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0]  pdm_q;

  rp_pkg::reg_addr_e      addr;
  logic                   strobe;
  logic                   hit;
  logic [`RP_DATA_W-1:0]  rd_val;
  rp_pkg::gain_t          wr_gain;
  rp_pkg::offset_t        wr_offs;
  rp_pkg::pdm_lvl_t       wr_pdm;

  assign addr   = rp_pkg::reg_addr_e'(sys_addr_i);
  assign strobe = sys_wen_i | sys_ren_i;

  // write data cut down to field width
  assign wr_gain = rp_pkg::gain_t'(sys_wdata_i[`RP_GAIN_W-1:0]);
  assign wr_offs = rp_pkg::offset_t'(sys_wdata_i[`RP_SMP_W-1:0]);
  assign wr_pdm  = rp_pkg::pdm_lvl_t'(sys_wdata_i[`RP_PDM_W-1:0]);

  ////////////////////////////////////////////////////////////
  // address decode and read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (addr)
      rp_pkg::REG_CTRL:      rd_val = `RP_DATA_W'(loop_q);
      // gain and offset read back sign extended
      rp_pkg::REG_ADC_GAIN0: rd_val = `RP_DATA_W'(signed'(adc_gain_q[0]));
      rp_pkg::REG_ADC_GAIN1: rd_val = `RP_DATA_W'(signed'(adc_gain_q[1]));
      rp_pkg::REG_ADC_OFFS0: rd_val = `RP_DATA_W'(signed'(adc_offs_q[0]));
      rp_pkg::REG_ADC_OFFS1: rd_val = `RP_DATA_W'(signed'(adc_offs_q[1]));
      rp_pkg::REG_DAC_GAIN0: rd_val = `RP_DATA_W'(signed'(dac_gain_q[0]));
      rp_pkg::REG_DAC_GAIN1: rd_val = `RP_DATA_W'(signed'(dac_gain_q[1]));
      rp_pkg::REG_DAC_OFFS0: rd_val = `RP_DATA_W'(signed'(dac_offs_q[0]));
      rp_pkg::REG_DAC_OFFS1: rd_val = `RP_DATA_W'(signed'(dac_offs_q[1]));
      rp_pkg::REG_PDM0:      rd_val = `RP_DATA_W'(pdm_q[0]);
      rp_pkg::REG_PDM1:      rd_val = `RP_DATA_W'(pdm_q[1]);
      rp_pkg::REG_PDM2:      rd_val = `RP_DATA_W'(pdm_q[2]);
      rp_pkg::REG_PDM3:      rd_val = `RP_DATA_W'(pdm_q[3]);
      // unmapped, reads 0 and flags an error
      default:               hit    = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // register storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      loop_q     <= 1'b0;
      adc_gain_q <= {`RP_CHN{rp_pkg::gain_t'(`RP_GAIN_UNITY)}};
      adc_offs_q <= '0;
      dac_gain_q <= {`RP_CHN{rp_pkg::gain_t'(`RP_GAIN_UNITY)}};
      dac_offs_q <= '0;
      pdm_q      <= '0;
    end else if (sys_wen_i) begin
      // new value visible in the ack cycle
      case (addr)
        rp_pkg::REG_CTRL:      loop_q        <= sys_wdata_i[0];
        rp_pkg::REG_ADC_GAIN0: adc_gain_q[0] <= wr_gain;
        rp_pkg::REG_ADC_GAIN1: adc_gain_q[1] <= wr_gain;
        rp_pkg::REG_ADC_OFFS0: adc_offs_q[0] <= wr_offs;
        rp_pkg::REG_ADC_OFFS1: adc_offs_q[1] <= wr_offs;
        rp_pkg::REG_DAC_GAIN0: dac_gain_q[0] <= wr_gain;
        rp_pkg::REG_DAC_GAIN1: dac_gain_q[1] <= wr_gain;
        rp_pkg::REG_DAC_OFFS0: dac_offs_q[0] <= wr_offs;
        rp_pkg::REG_DAC_OFFS1: dac_offs_q[1] <= wr_offs;
        rp_pkg::REG_PDM0:      pdm_q[0]      <= wr_pdm;
        rp_pkg::REG_PDM1:      pdm_q[1]      <= wr_pdm;
        rp_pkg::REG_PDM2:      pdm_q[2]      <= wr_pdm;
        rp_pkg::REG_PDM3:      pdm_q[3]      <= wr_pdm;
        default: ;
      endcase
    end
  end

  // bus response, one cycle after the strobe
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sys_ack_o   <= 1'b0;
      sys_err_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o <= strobe;
      sys_err_o <= strobe & ~hit;
      if (sys_ren_i) begin
        sys_rdata_o <= rd_val;
      end
    end
  end

  // settings out to the datapath
  assign cfg.digital_loop = loop_q;
  assign cfg.adc_gain     = adc_gain_q;
  assign cfg.adc_offs     = adc_offs_q;
  assign cfg.dac_gain     = dac_gain_q;
  assign cfg.dac_offs     = dac_offs_q;
  assign pdm_lvl_o        = pdm_q;

  // host waits for ack, so the ack cycle never carries a new strobe
  a_strobe_ack: assert property (@(posedge adc_clk) disable iff (top_rst)
    strobe |=> (sys_ack_o && !strobe));

endmodule

// ==== design/linear_calib.sv ====
`timescale 1ns/100ps

`include "rp_defs.svh"

module linear_calib (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  rp_pkg::sample_t  dat_i,
  input  rp_pkg::gain_t    gain_i,
  input  rp_pkg::offset_t  offs_i,
  output rp_pkg::sample_t  dat_o
);

  // full product, product after the binary point, sum with offset
  localparam int PROD_W = `RP_SMP_W + `RP_GAIN_W;
  localparam int SHFT_W = PROD_W - `RP_GAIN_SHIFT;
  localparam int SUM_W  = SHFT_W + 1;

  // saturation limits
  localparam rp_pkg::sample_t SMP_MAX = {1'b0, {(`RP_SMP_W-1){1'b1}}};
  localparam rp_pkg::sample_t SMP_MIN = {1'b1, {(`RP_SMP_W-1){1'b0}}};

  logic signed [PROD_W-1:0] prod_q;
  logic signed [SHFT_W-1:0] prod_shft;
  logic signed [SUM_W-1:0]  sum;

  // stage 1, signed multiply at full width
  always_ff @(posedge adc_clk) begin
    prod_q <= PROD_W'(dat_i) * PROD_W'(gain_i);
  end

  // drop the fraction bits, floor like an arithmetic shift
  assign prod_shft = prod_q[PROD_W-1:`RP_GAIN_SHIFT];
  assign sum       = SUM_W'(prod_shft) + SUM_W'(offs_i);

  // stage 2, offset and clip
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else if (sum > SUM_W'(SMP_MAX)) begin
      dat_o <= SMP_MAX;
    end else if (sum < SUM_W'(SMP_MIN)) begin
      dat_o <= SMP_MIN;
    end else begin
      dat_o <= rp_pkg::sample_t'(sum[`RP_SMP_W-1:0]);
    end
  end

  // same signs on product and offset never wrap to the other sign
  a_pos_no_wrap: assert property (@(posedge adc_clk) disable iff (top_rst)
    (!prod_q[PROD_W-1] && !offs_i[`RP_SMP_W-1]) |=> !dat_o[`RP_SMP_W-1]);
  a_neg_no_wrap: assert property (@(posedge adc_clk) disable iff (top_rst)
    (prod_q[PROD_W-1] && offs_i[`RP_SMP_W-1]) |=> dat_o[`RP_SMP_W-1]);

endmodule

// ==== design/adc_frontend.sv ====
`timescale 1ns/100ps

`include "rp_defs.svh"

module adc_frontend (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // raw offset-binary samples
  input  logic [`RP_CHN-1:0][`RP_SMP_W-1:0]      adc_dat_i,
  // calibrated dac samples for loopback
  input  rp_pkg::sample_t [`RP_CHN-1:0]          loop_dat_i,
  calib_cfg_if.adc_mp                            cfg,
  output rp_pkg::sample_t [`RP_CHN-1:0]          adc_dat_o
);

  for (genvar n = 0; n < `RP_CHN; n++) begin : g_chn

    rp_pkg::sample_t fmt_q;
    rp_pkg::sample_t cal_in;

    // offset binary to signed, keep msb and flip magnitude
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        fmt_q <= '0;
      end else begin
        fmt_q <= {adc_dat_i[n][`RP_SMP_W-1], ~adc_dat_i[n][`RP_SMP_W-2:0]};
      end
    end

    // loopback mux in front of the calibration
    assign cal_in = cfg.digital_loop ? loop_dat_i[n] : fmt_q;

    linear_calib u_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (cal_in),
      .gain_i  (cfg.adc_gain[n]),
      .offs_i  (cfg.adc_offs[n]),
      .dat_o   (adc_dat_o[n])
    );

  end

endmodule

// ==== design/dac_backend.sv ====
`timescale 1ns/100ps

`include "rp_defs.svh"

module dac_backend (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  input  rp_pkg::sample_t [`RP_CHN-1:0]          dac_dat_i,
  calib_cfg_if.dac_mp                            cfg,
  // calibrated samples, tapped before formatting
  output rp_pkg::sample_t [`RP_CHN-1:0]          loop_dat_o,
  // offset-binary samples to the converter
  output logic [`RP_CHN-1:0][`RP_SMP_W-1:0]      dac_dat_o
);

  for (genvar n = 0; n < `RP_CHN; n++) begin : g_chn

    linear_calib u_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (dac_dat_i[n]),
      .gain_i  (cfg.dac_gain[n]),
      .offs_i  (cfg.dac_offs[n]),
      .dat_o   (loop_dat_o[n])
    );

    // signed back to offset binary, same bit rule as the adc
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        dac_dat_o[n] <= '0;
      end else begin
        dac_dat_o[n] <= {loop_dat_o[n][`RP_SMP_W-1], ~loop_dat_o[n][`RP_SMP_W-2:0]};
      end
    end

  end

endmodule

// ==== design/pdm_modulator.sv ====
`timescale 1ns/100ps

`include "rp_defs.svh"

module pdm_modulator (
  input  logic                                 adc_clk,
  input  logic                                 top_rst,
  input  rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0]   pdm_lvl_i,
  output logic [`RP_PDM_CHN-1:0]               pdm_o
);

  // one extra bit holds acc plus level before the wrap
  localparam logic [`RP_PDM_W:0] RANGE = `RP_PDM_RANGE;

  for (genvar n = 0; n < `RP_PDM_CHN; n++) begin : g_chn

    logic [`RP_PDM_W-1:0] acc_q;
    logic [`RP_PDM_W:0]   acc_sum;

    assign acc_sum = {1'b0, acc_q} + {1'b0, pdm_lvl_i[n]};

    // first-order sigma delta, pulse on every wrap
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        acc_q    <= '0;
        pdm_o[n] <= 1'b0;
      end else if (acc_sum >= RANGE) begin
        acc_q    <= `RP_PDM_W'(acc_sum - RANGE);
        pdm_o[n] <= 1'b1;
      end else begin
        acc_q    <= `RP_PDM_W'(acc_sum);
        pdm_o[n] <= 1'b0;
      end
    end

    // residue below one period keeps the pulse count exact
    a_acc_range: assert property (@(posedge adc_clk) disable iff (top_rst)
      ({1'b0, acc_q} < RANGE));

  end

endmodule

// ==== design/rp_top.sv ====
`timescale 1ns/100ps

`include "rp_defs.svh"

module rp_top (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // converters
  input  logic [`RP_CHN-1:0][`RP_SMP_W-1:0]      adc_dat_i,
  input  rp_pkg::sample_t [`RP_CHN-1:0]          dac_dat_i,
  output rp_pkg::sample_t [`RP_CHN-1:0]          adc_dat_o,
  output logic [`RP_CHN-1:0][`RP_SMP_W-1:0]      dac_dat_o,
  // pdm outputs
  output logic [`RP_PDM_CHN-1:0]                 pdm_o,
  // register bus
  input  logic [`RP_ADDR_W-1:0]                  sys_addr_i,
  input  logic [`RP_DATA_W-1:0]                  sys_wdata_i,
  input  logic                                   sys_wen_i,
  input  logic                                   sys_ren_i,
  output logic [`RP_DATA_W-1:0]                  sys_rdata_o,
  output logic                                   sys_ack_o,
  output logic                                   sys_err_o
);

  ////////////////////////////////////////////////////////////
  // local wiring
  ////////////////////////////////////////////////////////////

  calib_cfg_if cfg ();

  rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_lvl;
  // dac calibration output fed back to the adc side
  rp_pkg::sample_t  [`RP_CHN-1:0]     loop_dat;

  ////////////////////////////////////////////////////////////
  // register block, next to the datapath
  ////////////////////////////////////////////////////////////

  rp_regs u_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .pdm_lvl_o   (pdm_lvl),
    .cfg         (cfg.regs_mp)
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .loop_dat_i (loop_dat),
    .cfg        (cfg.adc_mp),
    .adc_dat_o  (adc_dat_o)
  );

  dac_backend u_dac (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .dac_dat_i  (dac_dat_i),
    .cfg        (cfg.dac_mp),
    .loop_dat_o (loop_dat),
    .dac_dat_o  (dac_dat_o)
  );

  pdm_modulator u_pdm (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_lvl_i (pdm_lvl),
    .pdm_o     (pdm_o)
  );

endmodule

// ==== tests/tb_rp_top.sv ====
`timescale 1ns/100ps

`include "rp_defs.svh"

module tb_rp_top #(
  parameter int SEED = 83607
);

  localparam int CLK_HALF    = 20;
  localparam int ACK_TIMEOUT = 16;
  localparam int NUM_REGS    = 13;
  localparam int STREAM_LEN  = 64;
  localparam int SMP_MAX     = (1 << (`RP_SMP_W - 1)) - 1;
  localparam int SMP_MIN     = -(1 << (`RP_SMP_W - 1));

  // which output a stream is compared on
  localparam int MODE_ADC  = 0;
  localparam int MODE_DAC  = 1;
  localparam int MODE_LOOP = 2;

  logic                                adc_clk;
  logic                                top_rst;
  logic [`RP_CHN-1:0][`RP_SMP_W-1:0]   adc_dat_i;
  rp_pkg::sample_t [`RP_CHN-1:0]       dac_dat_i;
  rp_pkg::sample_t [`RP_CHN-1:0]       adc_dat_o;
  logic [`RP_CHN-1:0][`RP_SMP_W-1:0]   dac_dat_o;
  logic [`RP_PDM_CHN-1:0]              pdm_o;
  logic [`RP_ADDR_W-1:0]               sys_addr_i;
  logic [`RP_DATA_W-1:0]               sys_wdata_i;
  logic                                sys_wen_i;
  logic                                sys_ren_i;
  logic [`RP_DATA_W-1:0]               sys_rdata_o;
  logic                                sys_ack_o;
  logic                                sys_err_o;

  // calibration values as the host last wrote them
  rp_pkg::gain_t   adc_gain_m [`RP_CHN];
  rp_pkg::offset_t adc_offs_m [`RP_CHN];
  rp_pkg::gain_t   dac_gain_m [`RP_CHN];
  rp_pkg::offset_t dac_offs_m [`RP_CHN];

  // clipping seen by the model
  int sat_hi_cnt;
  int sat_lo_cnt;

  rp_top u_rp_top (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .dac_dat_i   (dac_dat_i),
    .adc_dat_o   (adc_dat_o),
    .dac_dat_o   (dac_dat_o),
    .pdm_o       (pdm_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  initial adc_clk = 1'b0;
  always #CLK_HALF adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s got 0x%0h expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference models
  ////////////////////////////////////////////////////////////

  // keep the sign bit, invert the 13 below it
  function automatic logic [`RP_SMP_W-1:0] offset_flip(input logic [`RP_SMP_W-1:0] x);
    return x ^ {1'b0, {(`RP_SMP_W-1){1'b1}}};
  endfunction

  // (sample * gain) >> 14 + offset, clipped to 14-bit signed
  function automatic rp_pkg::sample_t calib_model(input rp_pkg::sample_t s,
                                                  input rp_pkg::gain_t g,
                                                  input rp_pkg::offset_t o);
    int prod;
    int sum;
    prod = int'(s) * int'(g);
    sum  = (prod >>> `RP_GAIN_SHIFT) + int'(o);
    if (sum > SMP_MAX) begin
      sat_hi_cnt++;
      sum = SMP_MAX;
    end else if (sum < SMP_MIN) begin
      sat_lo_cnt++;
      sum = SMP_MIN;
    end
    return rp_pkg::sample_t'(sum);
  endfunction

  function automatic logic [`RP_DATA_W-1:0] reset_value(input logic [`RP_ADDR_W-1:0] a);
    case (rp_pkg::reg_addr_e'(a))
      rp_pkg::REG_ADC_GAIN0, rp_pkg::REG_ADC_GAIN1,
      rp_pkg::REG_DAC_GAIN0, rp_pkg::REG_DAC_GAIN1: return `RP_DATA_W'(`RP_GAIN_UNITY);
      default: return '0;
    endcase
  endfunction

  // readback of a write, field width and sign extension per register
  function automatic logic [`RP_DATA_W-1:0] field_value(input logic [`RP_ADDR_W-1:0] a,
                                                        input logic [`RP_DATA_W-1:0] d);
    case (rp_pkg::reg_addr_e'(a))
      rp_pkg::REG_CTRL: return {{(`RP_DATA_W-1){1'b0}}, d[0]};
      rp_pkg::REG_ADC_GAIN0, rp_pkg::REG_ADC_GAIN1,
      rp_pkg::REG_DAC_GAIN0, rp_pkg::REG_DAC_GAIN1:
        return {{(`RP_DATA_W-`RP_GAIN_W){d[`RP_GAIN_W-1]}}, d[`RP_GAIN_W-1:0]};
      rp_pkg::REG_ADC_OFFS0, rp_pkg::REG_ADC_OFFS1,
      rp_pkg::REG_DAC_OFFS0, rp_pkg::REG_DAC_OFFS1:
        return {{(`RP_DATA_W-`RP_SMP_W){d[`RP_SMP_W-1]}}, d[`RP_SMP_W-1:0]};
      default: return {{(`RP_DATA_W-`RP_PDM_W){1'b0}}, d[`RP_PDM_W-1:0]};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // bus access
  ////////////////////////////////////////////////////////////

  // called right after the strobe edge, ack due in this cycle
  task automatic wait_ack(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge adc_clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        abort_run({"timed out waiting for sys_ack_o after a ", what});
      end
    end while (sys_ack_o !== 1'b1);
    check("sys_ack_o latency", 32'(cycles), 32'd1);
  endtask

  task automatic bus_write(input logic [`RP_ADDR_W-1:0] addr,
                           input logic [`RP_DATA_W-1:0] data, input logic exp_err);
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= 1'b1;
    @(posedge adc_clk);
    sys_wen_i   <= 1'b0;
    wait_ack("write");
    check("sys_err_o", 32'(sys_err_o), 32'(exp_err));
  endtask

  task automatic bus_read(input logic [`RP_ADDR_W-1:0] addr, input logic exp_err,
                          output logic [`RP_DATA_W-1:0] data);
    @(posedge adc_clk);
    sys_addr_i <= addr;
    sys_ren_i  <= 1'b1;
    @(posedge adc_clk);
    sys_ren_i  <= 1'b0;
    wait_ack("read");
    check("sys_err_o", 32'(sys_err_o), 32'(exp_err));
    // read data belongs to the ack cycle
    data = sys_rdata_o;
  endtask

  task automatic load_calib();
    for (int c = 0; c < `RP_CHN; c++) begin
      bus_write(`RP_ADDR_W'(rp_pkg::REG_ADC_GAIN0 + 4 * c), 32'(adc_gain_m[c]), 1'b0);
      bus_write(`RP_ADDR_W'(rp_pkg::REG_ADC_OFFS0 + 4 * c), 32'(adc_offs_m[c]), 1'b0);
      bus_write(`RP_ADDR_W'(rp_pkg::REG_DAC_GAIN0 + 4 * c), 32'(dac_gain_m[c]), 1'b0);
      bus_write(`RP_ADDR_W'(rp_pkg::REG_DAC_OFFS0 + 4 * c), 32'(dac_offs_m[c]), 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sample streaming
  ////////////////////////////////////////////////////////////

  // new random samples every cycle, output compared lat cycles later
  task automatic stream_compare(input int mode, input int lat, input string name);
    logic [`RP_CHN-1:0][`RP_SMP_W-1:0] exp_q [$];
    logic [`RP_CHN-1:0][`RP_SMP_W-1:0] exp_v;
    logic [`RP_CHN-1:0][`RP_SMP_W-1:0] got_v;
    logic [`RP_SMP_W-1:0]              a_raw;
    rp_pkg::sample_t                   d_raw;
    rp_pkg::sample_t                   d_cal;
    for (int k = 0; k < STREAM_LEN; k++) begin
      @(posedge adc_clk);
      for (int c = 0; c < `RP_CHN; c++) begin
        a_raw = `RP_SMP_W'($urandom);
        d_raw = rp_pkg::sample_t'($urandom);
        adc_dat_i[c] <= a_raw;
        dac_dat_i[c] <= d_raw;
        d_cal = '0;
        if (mode != MODE_ADC) begin
          d_cal = calib_model(d_raw, dac_gain_m[c], dac_offs_m[c]);
        end
        case (mode)
          MODE_ADC: exp_v[c] = calib_model(offset_flip(a_raw), adc_gain_m[c], adc_offs_m[c]);
          MODE_DAC: exp_v[c] = offset_flip(d_cal);
          default:  exp_v[c] = calib_model(d_cal, adc_gain_m[c], adc_offs_m[c]);
        endcase
      end
      exp_q.push_back(exp_v);
      @(negedge adc_clk);
      // first lat outputs still hold older samples
      if (exp_q.size() > lat) begin
        exp_v = exp_q.pop_front();
        got_v = (mode == MODE_DAC) ? dac_dat_o : adc_dat_o;
        for (int c = 0; c < `RP_CHN; c++) begin
          check($sformatf("%s[%0d]", name, c), 32'(got_v[c]), 32'(exp_v[c]));
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic registers_readback();
    logic [`RP_ADDR_W-1:0] a;
    logic [`RP_DATA_W-1:0] wd;
    logic [`RP_DATA_W-1:0] rd;
    for (int i = 0; i < NUM_REGS; i++) begin
      a = `RP_ADDR_W'(4 * i);
      bus_read(a, 1'b0, rd);
      check($sformatf("sys_rdata_o reset @0x%02h", a), rd, reset_value(a));
    end
    // random upper bits must not leak into the readback
    for (int i = 0; i < NUM_REGS; i++) begin
      a  = `RP_ADDR_W'(4 * i);
      wd = $urandom;
      bus_write(a, wd, 1'b0);
      bus_read(a, 1'b0, rd);
      check($sformatf("sys_rdata_o @0x%02h", a), rd, field_value(a, wd));
    end
    // unmapped write leaves ctrl alone
    bus_write(`RP_ADDR_W'(rp_pkg::REG_CTRL), '0, 1'b0);
    bus_write(`RP_ADDR_W'(8'h01), '1, 1'b1);
    bus_read(`RP_ADDR_W'(rp_pkg::REG_CTRL), 1'b0, rd);
    check("sys_rdata_o ctrl", rd, '0);
    bus_read(`RP_ADDR_W'(8'h34), 1'b1, rd);
    check("sys_rdata_o @0x34", rd, '0);
    bus_read(`RP_ADDR_W'(8'hFC), 1'b1, rd);
    check("sys_rdata_o @0xfc", rd, '0);
  endtask

  task automatic adc_default_path();
    for (int c = 0; c < `RP_CHN; c++) begin
      adc_gain_m[c] = rp_pkg::gain_t'(`RP_GAIN_UNITY);
      dac_gain_m[c] = rp_pkg::gain_t'(`RP_GAIN_UNITY);
      adc_offs_m[c] = '0;
      dac_offs_m[c] = '0;
    end
    load_calib();
    bus_write(`RP_ADDR_W'(rp_pkg::REG_CTRL), '0, 1'b0);
    stream_compare(MODE_ADC, 3, "adc_dat_o");
  endtask

  task automatic adc_calibration();
    sat_hi_cnt = 0;
    sat_lo_cnt = 0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < `RP_CHN; c++) begin
        // round 0 uses full scale gains, the rest random
        if (r == 0) begin
          adc_gain_m[c] = (c == 0) ? 16'sh7FFF : 16'sh8000;
          adc_offs_m[c] = '0;
        end else begin
          adc_gain_m[c] = rp_pkg::gain_t'($urandom);
          adc_offs_m[c] = rp_pkg::offset_t'($urandom);
        end
      end
      load_calib();
      stream_compare(MODE_ADC, 3, "adc_dat_o");
    end
    if (sat_hi_cnt == 0 || sat_lo_cnt == 0) begin
      abort_run("adc calibration never reached both saturation limits");
    end
  endtask

  task automatic dac_path();
    for (int c = 0; c < `RP_CHN; c++) begin
      dac_gain_m[c] = rp_pkg::gain_t'($urandom);
      dac_offs_m[c] = rp_pkg::offset_t'($urandom);
    end
    load_calib();
    stream_compare(MODE_DAC, 3, "dac_dat_o");
  endtask

  // adc input keeps changing and must not show up
  task automatic loopback_path();
    bus_write(`RP_ADDR_W'(rp_pkg::REG_CTRL), 32'd1, 1'b0);
    stream_compare(MODE_LOOP, 4, "adc_dat_o loopback");
    bus_write(`RP_ADDR_W'(rp_pkg::REG_CTRL), '0, 1'b0);
  endtask

  task automatic pdm_density();
    int lvl [`RP_PDM_CHN];
    int cnt [`RP_PDM_CHN];
    lvl = '{0, 1, 100, 255};
    for (int n = 0; n < `RP_PDM_CHN; n++) begin
      bus_write(`RP_ADDR_W'(rp_pkg::REG_PDM0 + 4 * n), 32'(lvl[n]), 1'b0);
      cnt[n] = 0;
    end
    // let the accumulators settle
    repeat (2 * `RP_PDM_RANGE) @(posedge adc_clk);
    for (int k = 0; k < `RP_PDM_RANGE; k++) begin
      @(negedge adc_clk);
      for (int n = 0; n < `RP_PDM_CHN; n++) begin
        cnt[n] += int'(pdm_o[n]);
      end
    end
    for (int n = 0; n < `RP_PDM_CHN; n++) begin
      check($sformatf("pdm_o[%0d] high count", n), 32'(cnt[n]), 32'(lvl[n]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    top_rst     = 1'b1;
    adc_dat_i   = '0;
    dac_dat_i   = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    // outputs checked inside the 3 reset cycles
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    check("sys_ack_o", 32'(sys_ack_o), 32'd0);
    check("sys_err_o", 32'(sys_err_o), 32'd0);
    check("adc_dat_o", 32'(adc_dat_o), 32'd0);
    check("dac_dat_o", 32'(dac_dat_o), 32'd0);
    check("pdm_o", 32'(pdm_o), 32'd0);
    @(posedge adc_clk);
    top_rst <= 1'b0;
    registers_readback();
    adc_default_path();
    adc_calibration();
    dac_path();
    loopback_path();
    pdm_density();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+design
design/rp_pkg.sv
design/calib_cfg_if.sv
design/rp_regs.sv
design/linear_calib.sv
design/adc_frontend.sv
design/dac_backend.sv
design/pdm_modulator.sv
design/rp_top.sv
tests/tb_rp_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
LOG       ?= sim.log
SEED      ?= 83607
TOP       ?= tb_rp_top
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove build output and logs"
	@echo "variables: VERILATOR LOG SEED"

test:
	$(VERILATOR) --binary --assert --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(OBJ_DIR) -f sim.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@if grep -qxF '** PASS **' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
